// ==== src/daq_pkg.sv ====
`default_nettype none

package daq_pkg;

    // sample and lane geometry
    localparam int sample_w   = 16;
    localparam int lanes      = 4;
    localparam int max_rounds = 8;

    // data ram, 67 bytes used at most
    localparam int ram_aw = 7;

    localparam logic [7:0] frame_hdr = 8'hA5;

    // clk cycles per sclk half period
    localparam int sclk_div = 2;

    typedef logic [ram_aw-1:0] ram_addr_t;

    // adc opcodes, sent in the upper byte of the spi word
    typedef enum logic [7:0] {
        CMD_NOP  = 8'h00,
        CMD_CONV = 8'hC0
    } adc_cmd_e;

    typedef enum logic [2:0] {
        C_IDLE,
        C_CONV,
        C_PACK,
        C_SEND,
        C_DONE
    } console_state_e;

    typedef enum logic [1:0] {
        A_IDLE,
        A_SHIFT,
        A_GAP
    } adc_state_e;

endpackage

`default_nettype wire

// ==== src/sample_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// sample stream from the spi master to the packer
interface sample_if;
    logic                         valid;
    logic [1:0]                   lane;
    logic [daq_pkg::sample_w-1:0] data;
    // set on lane 3 of a round
    logic                         last;

    modport src (output valid, output lane, output data, output last);
    modport dst (input valid, input lane, input data, input last);
endinterface

`default_nettype wire

// ==== src/console.sv ====
`timescale 1ns/1ns
`default_nettype none

module console (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [3:0] rounds,
    output logic       busy,
    output logic       done,
    output logic       fs_conv,
    output logic       fs_pack,
    output logic       fs_send,
    output logic [2:0] round_idx,
    input  logic       fd_conv,
    input  logic       fd_pack,
    input  logic       fd_send
);

    daq_pkg::console_state_e state;
    logic [3:0] rounds_q;
    // second pack job closes the frame
    logic       tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= daq_pkg::C_IDLE;
            rounds_q  <= 4'd1;
            tail      <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            fs_conv   <= 1'b0;
            fs_pack   <= 1'b0;
            fs_send   <= 1'b0;
            round_idx <= 3'd0;
        end else begin
            // all strobes last one cycle
            fs_conv <= 1'b0;
            fs_pack <= 1'b0;
            fs_send <= 1'b0;
            done    <= 1'b0;
            case (state)
                daq_pkg::C_IDLE: begin
                    if (start) begin
                        if (rounds == 4'd0) begin
                            rounds_q <= 4'd1;
                        end else if (rounds > 4'(daq_pkg::max_rounds)) begin
                            rounds_q <= 4'(daq_pkg::max_rounds);
                        end else begin
                            rounds_q <= rounds;
                        end
                        round_idx <= 3'd0;
                        tail      <= 1'b0;
                        busy      <= 1'b1;
                        fs_pack   <= 1'b1;
                        state     <= daq_pkg::C_PACK;
                    end
                end
                daq_pkg::C_PACK: begin
                    if (fd_pack && !tail) begin
                        fs_conv <= 1'b1;
                        state   <= daq_pkg::C_CONV;
                    end else if (fd_pack) begin
                        fs_send <= 1'b1;
                        state   <= daq_pkg::C_SEND;
                    end
                end
                daq_pkg::C_CONV: begin
                    if (fd_conv) begin
                        if ({1'b0, round_idx} == rounds_q - 4'd1) begin
                            tail    <= 1'b1;
                            fs_pack <= 1'b1;
                            state   <= daq_pkg::C_PACK;
                        end else begin
                            round_idx <= round_idx + 3'd1;
                            fs_conv   <= 1'b1;
                        end
                    end
                end
                daq_pkg::C_SEND: begin
                    if (fd_send) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= daq_pkg::C_DONE;
                    end
                end
                default: begin
                    state <= daq_pkg::C_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/adc_spi.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_spi (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fs_conv,
    input  logic [2:0]                round_idx,
    output logic                      fd_conv,
    output logic [daq_pkg::lanes-1:0] adc_cs,
    output logic [daq_pkg::lanes-1:0] adc_sclk,
    output logic [daq_pkg::lanes-1:0] adc_mosi,
    input  logic [daq_pkg::lanes-1:0] adc_miso,
    sample_if.src                     smp
);

    daq_pkg::adc_state_e state;
    logic [1:0]  div_cnt;
    logic [3:0]  bit_cnt;
    logic [1:0]  lane_cnt;
    logic        cs_n;
    logic        sclk;
    logic        mosi;
    logic        tick;
    logic [15:0] cmd_word;
    logic [15:0] tx_word;
    logic [daq_pkg::lanes-1:0][daq_pkg::sample_w-1:0] rx_word;

    // opcode high, round index low
    assign cmd_word = {8'(daq_pkg::CMD_CONV), 5'd0, round_idx};
    assign tick     = (div_cnt == 2'(daq_pkg::sclk_div - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= daq_pkg::A_IDLE;
            div_cnt  <= 2'd0;
            bit_cnt  <= 4'd0;
            lane_cnt <= 2'd0;
            cs_n     <= 1'b1;
            sclk     <= 1'b0;
            mosi     <= 1'b0;
            fd_conv  <= 1'b0;
        end else begin
            fd_conv <= 1'b0;
            case (state)
                daq_pkg::A_IDLE: begin
                    if (fs_conv) begin
                        // msb is on the line before the first rising edge
                        cs_n    <= 1'b0;
                        mosi    <= cmd_word[15];
                        tx_word <= {cmd_word[14:0], 1'b0};
                        div_cnt <= 2'd0;
                        bit_cnt <= 4'd0;
                        state   <= daq_pkg::A_SHIFT;
                    end
                end
                daq_pkg::A_SHIFT: begin
                    if (tick) begin
                        div_cnt <= 2'd0;
                        sclk    <= ~sclk;
                        if (!sclk) begin
                            // rising edge, sample every lane
                            for (int i = 0; i < daq_pkg::lanes; i++) begin
                                rx_word[i] <= {rx_word[i][daq_pkg::sample_w-2:0], adc_miso[i]};
                            end
                        end else if (bit_cnt == 4'd15) begin
                            cs_n     <= 1'b1;
                            mosi     <= 1'b0;
                            lane_cnt <= 2'd0;
                            state    <= daq_pkg::A_GAP;
                        end else begin
                            // falling edge, next command bit
                            bit_cnt <= bit_cnt + 4'd1;
                            mosi    <= tx_word[15];
                            tx_word <= {tx_word[14:0], 1'b0};
                        end
                    end else begin
                        div_cnt <= div_cnt + 2'd1;
                    end
                end
                daq_pkg::A_GAP: begin
                    // one lane per cycle onto the sample stream
                    lane_cnt <= lane_cnt + 2'd1;
                    if (lane_cnt == 2'(daq_pkg::lanes - 1)) begin
                        fd_conv <= 1'b1;
                        state   <= daq_pkg::A_IDLE;
                    end
                end
                default: begin
                    state <= daq_pkg::A_IDLE;
                end
            endcase
        end
    end

    assign smp.valid = (state == daq_pkg::A_GAP);
    assign smp.lane  = lane_cnt;
    assign smp.data  = rx_word[lane_cnt];
    assign smp.last  = (lane_cnt == 2'(daq_pkg::lanes - 1));

    assign adc_cs   = {daq_pkg::lanes{cs_n}};
    assign adc_sclk = {daq_pkg::lanes{sclk}};
    assign adc_mosi = {daq_pkg::lanes{mosi}};

endmodule

`default_nettype wire

// ==== src/data_make.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_make (
    input  logic               clk,
    input  logic               rst,
    input  logic               fs_pack,
    output logic               fd_pack,
    sample_if.dst              smp,
    output daq_pkg::ram_addr_t ram_wa,
    output logic [7:0]         ram_wd,
    output logic               ram_we,
    output daq_pkg::ram_addr_t frame_len
);

    logic [daq_pkg::sample_w-1:0] smp_buf [daq_pkg::lanes];
    logic [daq_pkg::sample_w-1:0] cur_word;
    logic               hdr_done;
    logic               drain_on;
    logic               tail_req;
    logic               tail_step;
    logic [2:0]         byte_idx;
    logic [7:0]         drain_byte;
    logic [7:0]         csum;
    daq_pkg::ram_addr_t wptr;

    // a round arrives in four cycles, so it is buffered and written out over eight
    always_ff @(posedge clk) begin
        if (smp.valid) begin
            smp_buf[smp.lane] <= smp.data;
        end
    end

    assign cur_word   = smp_buf[byte_idx[2:1]];
    assign drain_byte = byte_idx[0] ? cur_word[7:0] : cur_word[15:8];

    always_ff @(posedge clk) begin
        if (rst) begin
            ram_we    <= 1'b0;
            fd_pack   <= 1'b0;
            hdr_done  <= 1'b0;
            drain_on  <= 1'b0;
            tail_req  <= 1'b0;
            tail_step <= 1'b0;
            byte_idx  <= 3'd0;
            csum      <= 8'd0;
            wptr      <= '0;
            frame_len <= '0;
        end else begin
            ram_we  <= 1'b0;
            fd_pack <= 1'b0;
            // closing request may come while a round is still draining
            if (fs_pack && hdr_done) begin
                tail_req <= 1'b1;
            end
            if (smp.valid && smp.last) begin
                drain_on <= 1'b1;
                byte_idx <= 3'd0;
            end
            if (fs_pack && !hdr_done) begin
                ram_we   <= 1'b1;
                ram_wa   <= '0;
                ram_wd   <= daq_pkg::frame_hdr;
                wptr     <= daq_pkg::ram_addr_t'(2);
                csum     <= 8'd0;
                hdr_done <= 1'b1;
                fd_pack  <= 1'b1;
            end else if (drain_on) begin
                ram_we   <= 1'b1;
                ram_wa   <= wptr;
                ram_wd   <= drain_byte;
                wptr     <= wptr + daq_pkg::ram_addr_t'(1);
                csum     <= csum ^ drain_byte;
                byte_idx <= byte_idx + 3'd1;
                if (byte_idx == 3'd7) begin
                    drain_on <= 1'b0;
                end
            end else if (tail_req) begin
                ram_we <= 1'b1;
                if (!tail_step) begin
                    // length counts sample bytes only
                    ram_wa    <= daq_pkg::ram_addr_t'(1);
                    ram_wd    <= 8'(wptr - daq_pkg::ram_addr_t'(2));
                    tail_step <= 1'b1;
                end else begin
                    ram_wa    <= wptr;
                    ram_wd    <= csum;
                    frame_len <= wptr + daq_pkg::ram_addr_t'(1);
                    tail_step <= 1'b0;
                    tail_req  <= 1'b0;
                    hdr_done  <= 1'b0;
                    fd_pack   <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ram_data.sv ====
`timescale 1ns/1ns
`default_nettype none

module ram_data (
    input  logic               clk,
    input  daq_pkg::ram_addr_t wa,
    input  logic [7:0]         wd,
    input  logic               we,
    input  daq_pkg::ram_addr_t ra,
    output logic [7:0]         rd
);

    logic [7:0] mem [2**daq_pkg::ram_aw];

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
        rd <= mem[ra];
    end

endmodule

`default_nettype wire

// ==== src/com_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module com_tx (
    input  logic               clk,
    input  logic               rst,
    input  logic               fs_send,
    input  daq_pkg::ram_addr_t frame_len,
    output daq_pkg::ram_addr_t ram_ra,
    input  logic [7:0]         ram_rd,
    output logic               fd_send,
    output logic               tx_valid,
    output logic [3:0]         tx_data
);

    logic       active;
    // 0 first fetch, 1 high nibble, 2 low nibble, 3 idle gap
    logic [1:0] ph;
    logic [3:0] lo_nib;
    logic       last_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            ph        <= 2'd0;
            ram_ra    <= '0;
            last_byte <= 1'b0;
            fd_send   <= 1'b0;
            tx_valid  <= 1'b0;
            tx_data   <= 4'd0;
        end else begin
            fd_send <= 1'b0;
            if (!active) begin
                tx_valid <= 1'b0;
                if (fs_send) begin
                    active <= 1'b1;
                    ram_ra <= '0;
                    ph     <= 2'd0;
                end
            end else begin
                case (ph)
                    2'd0: begin
                        // wait out the ram read latency
                        ph <= 2'd1;
                    end
                    2'd1: begin
                        tx_valid  <= 1'b1;
                        tx_data   <= ram_rd[7:4];
                        lo_nib    <= ram_rd[3:0];
                        last_byte <= (ram_ra == frame_len - daq_pkg::ram_addr_t'(1));
                        if (ram_ra != frame_len - daq_pkg::ram_addr_t'(1)) begin
                            ram_ra <= ram_ra + daq_pkg::ram_addr_t'(1);
                        end
                        ph <= 2'd2;
                    end
                    2'd2: begin
                        tx_valid <= 1'b1;
                        tx_data  <= lo_nib;
                        ph       <= 2'd3;
                    end
                    default: begin
                        tx_valid <= 1'b0;
                        if (last_byte) begin
                            active  <= 1'b0;
                            fd_send <= 1'b1;
                            ph      <= 2'd0;
                        end else begin
                            // next byte is already on ram_rd
                            ph <= 2'd1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/daq_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module daq_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [3:0]                rounds,
    output logic                      busy,
    output logic                      done,
    output logic [daq_pkg::lanes-1:0] adc_cs,
    output logic [daq_pkg::lanes-1:0] adc_sclk,
    output logic [daq_pkg::lanes-1:0] adc_mosi,
    input  logic [daq_pkg::lanes-1:0] adc_miso,
    output logic                      tx_valid,
    output logic [3:0]                tx_data
);

    // fire pairs
    logic fs_conv, fd_conv;
    logic fs_pack, fd_pack;
    logic fs_send, fd_send;

    logic [2:0] round_idx;

    // ram ports
    daq_pkg::ram_addr_t ram_wa;
    daq_pkg::ram_addr_t ram_ra;
    daq_pkg::ram_addr_t frame_len;
    logic [7:0]         ram_wd;
    logic [7:0]         ram_rd;
    logic               ram_we;

    sample_if smp ();

    console
    console_dut(
        .clk(clk),
        .rst(rst),
        .start(start),
        .rounds(rounds),
        .busy(busy),
        .done(done),
        .fs_conv(fs_conv),
        .fs_pack(fs_pack),
        .fs_send(fs_send),
        .round_idx(round_idx),
        .fd_conv(fd_conv),
        .fd_pack(fd_pack),
        .fd_send(fd_send)
    );

    adc_spi
    adc_spi_dut(
        .clk(clk),
        .rst(rst),
        .fs_conv(fs_conv),
        .round_idx(round_idx),
        .fd_conv(fd_conv),
        .adc_cs(adc_cs),
        .adc_sclk(adc_sclk),
        .adc_mosi(adc_mosi),
        .adc_miso(adc_miso),
        .smp(smp.src)
    );

    data_make
    data_make_dut(
        .clk(clk),
        .rst(rst),
        .fs_pack(fs_pack),
        .fd_pack(fd_pack),
        .smp(smp.dst),
        .ram_wa(ram_wa),
        .ram_wd(ram_wd),
        .ram_we(ram_we),
        .frame_len(frame_len)
    );

    ram_data
    ram_data_dut(
        .clk(clk),
        .wa(ram_wa),
        .wd(ram_wd),
        .we(ram_we),
        .ra(ram_ra),
        .rd(ram_rd)
    );

    com_tx
    com_tx_dut(
        .clk(clk),
        .rst(rst),
        .fs_send(fs_send),
        .frame_len(frame_len),
        .ram_ra(ram_ra),
        .ram_rd(ram_rd),
        .fd_send(fd_send),
        .tx_valid(tx_valid),
        .tx_data(tx_data)
    );

endmodule

`default_nettype wire

// ==== dv/daq_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module daq_asserts (
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic       done,
    input logic       fs_conv,
    input logic       fd_conv,
    input logic       fs_pack,
    input logic       fd_pack,
    input logic       fs_send,
    input logic       fd_send,
    input logic [3:0] adc_cs,
    input logic       tx_valid
);

    // strobes last exactly one cycle
    a_fs_conv: assert property (@(posedge clk) disable iff (rst) fs_conv |=> !fs_conv)
        else $error("fs_conv held longer than one cycle");
    a_fd_conv: assert property (@(posedge clk) disable iff (rst) fd_conv |=> !fd_conv)
        else $error("fd_conv held longer than one cycle");
    a_fs_pack: assert property (@(posedge clk) disable iff (rst) fs_pack |=> !fs_pack)
        else $error("fs_pack held longer than one cycle");
    a_fd_pack: assert property (@(posedge clk) disable iff (rst) fd_pack |=> !fd_pack)
        else $error("fd_pack held longer than one cycle");
    a_fs_send: assert property (@(posedge clk) disable iff (rst) fs_send |=> !fs_send)
        else $error("fs_send held longer than one cycle");
    a_fd_send: assert property (@(posedge clk) disable iff (rst) fd_send |=> !fd_send)
        else $error("fd_send held longer than one cycle");
    a_done: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held longer than one cycle");

    // no conversion outside a run
    a_cs_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> adc_cs == 4'hF)
        else $error("adc_cs low while idle");

    // two nibbles then a gap
    a_tx_second: assert property (@(posedge clk) disable iff (rst) $rose(tx_valid) |=> tx_valid)
        else $error("tx_valid high for a single cycle");
    a_tx_gap: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && $past(tx_valid)) |=> !tx_valid)
        else $error("tx_valid high for more than two cycles");

endmodule

bind daq_top daq_asserts i_asserts (
    .clk(clk),
    .rst(rst),
    .busy(busy),
    .done(done),
    .fs_conv(fs_conv),
    .fd_conv(fd_conv),
    .fs_pack(fs_pack),
    .fd_pack(fd_pack),
    .fs_send(fs_send),
    .fd_send(fd_send),
    .adc_cs(adc_cs),
    .tx_valid(tx_valid)
);

`default_nettype wire

// ==== dv/daq_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module daq_tb;

    logic       clk;
    logic       rst;
    logic       start;
    logic [3:0] rounds;
    logic       busy;
    logic       done;
    logic [3:0] adc_cs;
    logic [3:0] adc_sclk;
    logic [3:0] adc_mosi;
    logic [3:0] adc_miso;
    logic       tx_valid;
    logic [3:0] tx_data;

    // test table from the vector file
    string       test_name [$];
    int          test_rounds [$];
    int          test_base [$];
    logic [15:0] words [$];
    bit          load_error = 1'b0;

    // test in progress
    string       cur_name = "none";
    int          cur_base = 0;
    int          cur_rounds = 0;
    bit          run_active = 1'b0;

    // monitor state
    int          spi_frames = 0;
    int          done_count = 0;
    logic [7:0]  rx_bytes [$];
    logic [3:0]  hi_nib = 4'd0;
    bit          have_hi = 1'b0;
    logic [15:0] mosi_word [4];
    int          mosi_bits [4];
    logic [3:0]  mon_cs = 4'hF;
    logic [3:0]  mon_sclk = 4'h0;

    // adc lane models
    logic [3:0]  adc_prev_cs = 4'hF;
    logic [3:0]  adc_prev_sclk = 4'h0;
    logic [15:0] miso_sr [4];

    int          checks = 0;
    int          errors = 0;
    int          cycle = 0;
    int          cycle_limit = 0;

    daq_top i_dut (
        .clk(clk),
        .rst(rst),
        .start(start),
        .rounds(rounds),
        .busy(busy),
        .done(done),
        .adc_cs(adc_cs),
        .adc_sclk(adc_sclk),
        .adc_mosi(adc_mosi),
        .adc_miso(adc_miso),
        .tx_valid(tx_valid),
        .tx_data(tx_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("ERROR %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
        end
    endtask

    function automatic logic [15:0] sample_word(input int round, input int lane);
        if (round < cur_rounds) begin
            return words[cur_base + round * 4 + lane];
        end
        return 16'h0000;
    endfunction

    // opcode in the upper byte, round index in the lower
    task automatic inspect_command(input int lane);
        logic [15:0] expected;
        expected = {daq_pkg::CMD_CONV, 8'(spi_frames)};
        compare_value($sformatf("lane %0d command bits", lane), 32'd16, 32'(mosi_bits[lane]));
        compare_value($sformatf("lane %0d command word", lane), 32'(expected),
                      32'(mosi_word[lane]));
    endtask

    // adc lanes shift on falling sclk and put the msb out when cs falls
    always @(posedge clk) begin
        #1;
        for (int i = 0; i < 4; i++) begin
            if (adc_prev_cs[i] && !adc_cs[i]) begin
                miso_sr[i] = sample_word(spi_frames, i);
                adc_miso[i] = miso_sr[i][15];
            end else if (!adc_cs[i] && adc_prev_sclk[i] && !adc_sclk[i]) begin
                miso_sr[i] = {miso_sr[i][14:0], 1'b0};
                adc_miso[i] = miso_sr[i][15];
            end
        end
        adc_prev_cs = adc_cs;
        adc_prev_sclk = adc_sclk;
    end

    // outputs are sampled mid cycle
    always @(negedge clk) begin
        if (done) begin
            done_count = done_count + 1;
        end
        if (run_active) begin
            if (done) begin
                compare_value("busy at done", 32'd0, 32'(busy));
                run_active = 1'b0;
            end else begin
                compare_value("busy during run", 32'd1, 32'(busy));
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (mon_cs[i] && !adc_cs[i]) begin
                mosi_word[i] = 16'h0000;
                mosi_bits[i] = 0;
            end else if (!adc_cs[i] && !mon_sclk[i] && adc_sclk[i]) begin
                mosi_word[i] = {mosi_word[i][14:0], adc_mosi[i]};
                mosi_bits[i] = mosi_bits[i] + 1;
            end else if (!mon_cs[i] && adc_cs[i]) begin
                inspect_command(i);
            end
        end
        if (!mon_cs[0] && adc_cs[0]) begin
            spi_frames = spi_frames + 1;
        end
        // high nibble first
        if (tx_valid) begin
            if (have_hi) begin
                rx_bytes.push_back({hi_nib, tx_data});
                have_hi = 1'b0;
            end else begin
                hi_nib = tx_data;
                have_hi = 1'b1;
            end
        end
        mon_cs = adc_cs;
        mon_sclk = adc_sclk;
    end

    task automatic load_tests();
        int          fd;
        int          code;
        int          c;
        int          n_rounds;
        string       tok;
        logic [15:0] w;
        bit          stop;
        fd = $fopen("dv/daq_tests.txt", "r");
        if (fd == 0) begin
            load_error = 1'b1;
            return;
        end
        stop = 1'b0;
        while (!stop) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                stop = 1'b1;
            end else if (tok.getc(0) == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c >= 0) begin
                    c = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%d", n_rounds);
                if (code != 1 || n_rounds < 1 || n_rounds > daq_pkg::max_rounds) begin
                    $display("test %s has no round count from 1 to 8", tok);
                    load_error = 1'b1;
                    stop = 1'b1;
                end else begin
                    test_name.push_back(tok);
                    test_rounds.push_back(n_rounds);
                    test_base.push_back(words.size());
                    for (int k = 0; k < n_rounds * 4; k++) begin
                        code = $fscanf(fd, "%h", w);
                        if (code != 1) begin
                            load_error = 1'b1;
                        end
                        words.push_back(w);
                    end
                end
            end
        end
        $fclose(fd);
        if (test_name.size() == 0) begin
            load_error = 1'b1;
        end
    endtask

    // frame is header, length, sample bytes, xor of sample bytes
    task automatic verify_frame();
        logic [7:0]  exp_q [$];
        logic [7:0]  csum;
        logic [15:0] w;
        int          n;
        csum = 8'h00;
        exp_q.push_back(daq_pkg::frame_hdr);
        exp_q.push_back(8'(cur_rounds * 8));
        for (int k = 0; k < cur_rounds * 4; k++) begin
            w = words[cur_base + k];
            exp_q.push_back(w[15:8]);
            exp_q.push_back(w[7:0]);
            csum = csum ^ w[15:8] ^ w[7:0];
        end
        exp_q.push_back(csum);
        compare_value("byte count", exp_q.size(), rx_bytes.size());
        n = (rx_bytes.size() < exp_q.size()) ? rx_bytes.size() : exp_q.size();
        for (int k = 0; k < n; k++) begin
            compare_value($sformatf("byte %0d", k), 32'(exp_q[k]), 32'(rx_bytes[k]));
        end
    endtask

    task automatic idle_after_reset();
        cur_name = "reset";
        compare_value("busy", 32'd0, 32'(busy));
        compare_value("done", 32'd0, 32'(done));
        compare_value("tx_valid", 32'd0, 32'(tx_valid));
        compare_value("adc_sclk", 32'd0, 32'(adc_sclk));
        compare_value("adc_mosi", 32'd0, 32'(adc_mosi));
        compare_value("adc_cs", 32'hF, 32'(adc_cs));
    endtask

    task automatic run_test(input int t);
        cur_name = test_name[t];
        cur_base = test_base[t];
        cur_rounds = test_rounds[t];
        spi_frames = 0;
        done_count = 0;
        have_hi = 1'b0;
        rx_bytes.delete();
        @(posedge clk);
        #1;
        start = 1'b1;
        rounds = 4'(cur_rounds);
        @(posedge clk);
        #1;
        start = 1'b0;
        run_active = 1'b1;
        // a second start while busy must be ignored
        repeat (12) @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (done_count == 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        #1;
        compare_value("done strobes", 32'd1, 32'(done_count));
        compare_value("busy after done", 32'd0, 32'(busy));
        compare_value("spi frames", 32'(cur_rounds), 32'(spi_frames));
        compare_value("leftover nibble", 32'd0, 32'(have_hi));
        verify_frame();
    endtask

    initial begin
        int total_rounds;
        rst = 1'b1;
        start = 1'b0;
        rounds = 4'd0;
        adc_miso = 4'd0;
        load_tests();
        if (load_error) begin
            $display("the test vector file dv/daq_tests.txt could not be read");
            $display("SOME TESTS FAILED");
        end else begin
            total_rounds = 0;
            foreach (test_rounds[t]) begin
                total_rounds = total_rounds + test_rounds[t];
            end
            // a round takes about 100 cycles including its share of the send
            cycle_limit = 150 * total_rounds + 150 * test_rounds.size() + 100;
            repeat (3) @(posedge clk);
            #1;
            rst = 1'b0;
            @(negedge clk);
            idle_after_reset();
            foreach (test_name[t]) begin
                run_test(t);
            end
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/daq_tests.txt ====
# columns: test name, round count, then round count times 4 sample words in hex
# words go round by round, lanes 0 to 3 within a round
one_round 1 1234 abcd 0000 ffff
zero_words 1 0000 0000 0000 0000
two_rounds 2 8001 7ffe 5555 aaaa 0f0f f0f0 c3c3 3c3c
three_rounds 3 0102 0304 0506 0708 1111 2222 3333 4444 dead beef cafe f00d
four_rounds 4 a5a5 5a5a 0001 8000 ff00 00ff 7f7f 8080 1357 2468 9bdf ace0 4321 8765 cba9 0fed
five_rounds 5 1001 2002 3003 4004 5005 6006 7007 8008 9009 a00a b00b c00c d00d e00e f00f 0ff0 1ee1 2dd2 3cc3 4bb4
eight_rounds 8 0123 4567 89ab cdef fedc ba98 7654 3210 1111 2222 4444 8888 eeee dddd bbbb 7777 0f1e 2d3c 4b5a 6978 8796 a5b4 c3d2 e1f0 ffff 0000 ffff 0000 5a5a a5a5 3c3c c3c3

// ==== daq.f ====
src/daq_pkg.sv
src/sample_if.sv
src/console.sv
src/adc_spi.sv
src/data_make.sv
src/ram_data.sv
src/com_tx.sv
src/daq_top.sv
dv/daq_asserts.sv
dv/daq_tb.sv

// ==== Makefile ====
TOP := daq_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f daq.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
